//--- Bender.yml
package:
  name: bank_sched

sources:
  - rtl/schedPkg.sv
  - rtl/groupIf.sv
  - rtl/cmdDispatch.sv
  - rtl/groupQueue.sv
  - rtl/groupArbiter.sv
  - rtl/cmdIssue.sv
  - rtl/bankSchedTop.sv
  - target: simulation
    files:
      - testbench/bankSched_asserts.sv
      - testbench/tbBankSched.sv

//--- files.f
rtl/schedPkg.sv
rtl/groupIf.sv
rtl/cmdDispatch.sv
rtl/groupQueue.sv
rtl/groupArbiter.sv
rtl/cmdIssue.sv
rtl/bankSchedTop.sv
testbench/bankSched_asserts.sv
testbench/tbBankSched.sv

//--- rtl/bankSchedTop.sv
`timescale 1ns/1ps

// Command scheduler in front of the bank groups
module bankSchedTop import schedPkg::*; #(
    parameter int QUEUE_DEPTH = 4,  // Entries per group, power of two
    parameter int BURST_LIMIT = 3   // Max consecutive grants per group
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmdValid,
    input  logic [15:0] cmd,
    output logic        issueValid,
    output cmdOp_t      issueOp,
    output logic [1:0]  issueGroup,
    output logic [1:0]  issueBank,
    output logic [9:0]  issueRow,
    output logic [8:0]  issueCol,
    output logic        issueChop,
    output logic        overflow    // Any queue dropped a command
);

    logic [NUM_GROUPS-1:0] push;
    logic [NUM_GROUPS-1:0] qOverflow;
    logic [1:0]            sel;
    cmdWord_t              pushWord;

    groupIf grpBus [NUM_GROUPS] ();

    cmdDispatch dispatch_i (
        .cmdValid (cmdValid),
        .cmd      (cmdWord_t'(cmd)),
        .push     (push),
        .pushWord (pushWord)
    );

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : gQueue
        groupQueue #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .BURST_LIMIT (BURST_LIMIT)
        ) queue_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (push[g]),
            .pushWord (pushWord),
            .grp      (grpBus[g]),
            .overflow (qOverflow[g])
        );
    end

    groupArbiter arbiter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .grp   (grpBus),
        .sel   (sel)
    );

    cmdIssue issue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .grp        (grpBus),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueGroup (issueGroup),
        .issueBank  (issueBank),
        .issueRow   (issueRow),
        .issueCol   (issueCol),
        .issueChop  (issueChop)
    );

    assign overflow = |qOverflow;

endmodule

//--- rtl/cmdDispatch.sv
`timescale 1ns/1ps

// Sorts incoming commands onto the per-group queues
module cmdDispatch import schedPkg::*; (
    input  logic                  cmdValid,  // Single-cycle strobe
    input  cmdWord_t              cmd,
    output logic [NUM_GROUPS-1:0] push,      // One-hot, at most one queue
    output cmdWord_t              pushWord
);

    logic isNop;

    assign isNop = (cmd.op == NOP);  // No-ops never take a queue slot

    // Group field to one-hot push
    always_comb begin
        push = '0;
        if (cmdValid && !isNop) begin
            push[cmd.group] = 1'b1;
        end
    end

    // Same word fans out to every queue, push picks the taker
    assign pushWord = cmd;

endmodule

//--- rtl/cmdIssue.sv
`timescale 1ns/1ps

// Takes the granted queue head, decodes the payload and registers it
module cmdIssue import schedPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  sel,         // Registered grant group from arbiter
    groupIf.monitor     grp [NUM_GROUPS],
    output logic        issueValid,  // One-cycle strobe
    output cmdOp_t      issueOp,
    output logic [1:0]  issueGroup,
    output logic [1:0]  issueBank,
    output logic [9:0]  issueRow,    // ACT only
    output logic [8:0]  issueCol,    // RD/WR only
    output logic        issueChop    // RD/WR only
);

    logic [NUM_GROUPS-1:0] start;
    cmdWord_t              head [NUM_GROUPS];
    cmdWord_t              selHead;
    logic                  anyStart;

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : gUnpack
        assign start[g] = grp[g].start;
        assign head[g]  = grp[g].head;
    end

    // Starts are one-hot
    always_comb begin
        selHead = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (start[g]) begin
                selHead = head[g];
            end
        end
    end

    assign anyStart = |start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= anyStart;
        end
    end

    // Unused view keeps old contents
    always_ff @(posedge clk) begin
        if (anyStart) begin
            issueOp   <= selHead.op;
            issueBank <= selHead.payload.rowView.bank;  // Same bits in both views
            if (selHead.op == ACT) begin
                issueRow <= selHead.payload.rowView.row;
            end else begin
                issueCol  <= selHead.payload.colView.col;
                issueChop <= selHead.payload.colView.chop;
            end
        end
    end

    // sel was loaded on the same edge as issueValid, so it names the issued group
    assign issueGroup = sel;

endmodule

//--- rtl/groupArbiter.sv
`timescale 1ns/1ps

// Bank-group arbiter
// Stays on a group until it empties or hits its burst limit, then rotates A-B-C-D
module groupArbiter import schedPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    groupIf.arbiter  grp [NUM_GROUPS],
    output logic [1:0] sel  // Group of the current or last grant
);

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        GROUP_A = 3'd1,
        GROUP_B = 3'd2,
        GROUP_C = 3'd3,
        GROUP_D = 3'd4
    } arbState_t;

    arbState_t             curState;
    arbState_t             nextState;
    logic [NUM_GROUPS-1:0] req;
    logic [NUM_GROUPS-1:0] done;
    logic [NUM_GROUPS-1:0] start;
    logic [1:0]            curIdx;  // Group index of curState

    // Flatten the interface array, constant indices only
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : gUnpack
        assign req[g]       = grp[g].req;
        assign done[g]      = grp[g].done;
        assign grp[g].start = start[g];
    end

    // Next requester after 'from' in rotation, skipping 'from' itself
    function automatic arbState_t rotate(input logic [1:0] from,
                                         input logic [NUM_GROUPS-1:0] r);
        logic [1:0] idx;
        rotate = IDLE;
        for (int k = NUM_GROUPS - 1; k >= 1; k--) begin
            idx = from + 2'(k);  // Wraps past D to A
            if (r[idx]) begin
                rotate = arbState_t'({1'b0, idx} + 3'd1);  // Nearest wins, checked last
            end
        end
    endfunction

    assign curIdx = 2'(curState - GROUP_A);  // Meaningless in IDLE, not used there

    // Next state and Mealy start pulses
    always_comb begin
        start     = '0;
        nextState = curState;
        case (curState)
            IDLE: begin
                // Fixed priority, A first
                for (int k = NUM_GROUPS - 1; k >= 0; k--) begin
                    if (req[k]) begin
                        nextState = arbState_t'(3'(k + 1));
                    end
                end
                if (nextState != IDLE) begin
                    start[2'(nextState - GROUP_A)] = 1'b1;  // Grant without a dead cycle
                end
            end
            default: begin
                if (req[curIdx] && !done[curIdx]) begin
                    start[curIdx] = 1'b1;  // Keep bursting
                end else begin
                    nextState = rotate(curIdx, req);  // Hand-over cycle, no start
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            curState <= IDLE;
            sel      <= '0;
        end else begin
            curState <= nextState;
            if (nextState != IDLE) begin
                sel <= 2'(nextState - GROUP_A);  // Holds through IDLE
            end
        end
    end

endmodule

//--- rtl/groupIf.sv
`timescale 1ns/1ps

// Handshake between one group queue, the arbiter and the issue stage
interface groupIf import schedPkg::*; ();

    logic     req;    // Queue not empty
    logic     done;   // Burst limit reached
    logic     start;  // Head popped on this edge
    cmdWord_t head;   // Oldest queued command

    // Arbiter sees demand and drives the grant pulse
    modport arbiter (input req, input done, output start);

    // Queue side
    modport queue (output req, output done, output head, input start);

    // Issue stage only watches grants and heads
    modport monitor (input start, input head);

endinterface

//--- rtl/groupQueue.sv
`timescale 1ns/1ps

// One bank group's command FIFO plus its burst counter
module groupQueue import schedPkg::*; #(
    parameter int QUEUE_DEPTH = 4,  // Power of two
    parameter int BURST_LIMIT = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  cmdWord_t pushWord,
    groupIf.queue    grp,
    output logic     overflow       // Sticky until reset
);

    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);
    localparam int BURST_W = $clog2(BURST_LIMIT + 1);

    cmdWord_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   fill;      // Entries held
    logic [BURST_W-1:0] burstCnt;  // Back-to-back grants
    logic               full;
    logic               doWrite;
    logic               doRead;
    logic               doneReg;

    assign full    = (fill == CNT_W'(QUEUE_DEPTH));
    assign doWrite = push && !full;             // Push into full is lost
    assign doRead  = grp.start && (fill != '0); // Arbiter only starts on req

    // Storage, no reset needed
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= pushWord;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps, depth is 2^n
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // Both or neither
            endcase
        end
    end

    // Counts consecutive starts, any idle cycle restarts the count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burstCnt <= '0;
            doneReg  <= 1'b0;
        end else if (grp.start) begin
            burstCnt <= burstCnt + 1'b1;
            doneReg  <= (burstCnt + 1'b1 == BURST_W'(BURST_LIMIT));  // Limit hit
        end else begin
            burstCnt <= '0;
            doneReg  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    assign grp.req  = (fill != '0);
    assign grp.done = doneReg;
    assign grp.head = mem[rdPtr];  // Valid only while req

endmodule

//--- rtl/schedPkg.sv
package schedPkg;

    // Bank-group count, the arbiter states and the 2-bit group field assume 4
    localparam int NUM_GROUPS = 4;

    typedef enum logic [1:0] {
        ACT = 2'd0,  // Activate, row view
        RD  = 2'd1,  // Read, column view
        WR  = 2'd2,  // Write, column view
        NOP = 2'd3   // Filtered at dispatch
    } cmdOp_t;

    // Row address for activate
    typedef struct packed {
        logic [1:0] bank;
        logic [9:0] row;
    } rowView_t;

    // Column address for read and write
    typedef struct packed {
        logic [1:0] bank;
        logic       chop;  // Burst chop
        logic [8:0] col;
    } colView_t;

    // 12-bit payload, meaning set by the opcode
    typedef union packed {
        rowView_t rowView;
        colView_t colView;
    } cmdPayload_u;

    // Full 16-bit command word
    typedef struct packed {
        cmdOp_t      op;
        logic [1:0]  group;    // Target bank group
        cmdPayload_u payload;
    } cmdWord_t;

endpackage

//--- testbench/bankSched_asserts.sv
`timescale 1ns/1ps

// Concurrent checks on the scheduler's top-level ports
module bankSchedAsserts import schedPkg::*; #(
    parameter int BURST_LIMIT = 3
) (
    input logic        clk,
    input logic        rst_n,
    input logic        cmdValid,
    input logic [15:0] cmd,
    input logic        issueValid,
    input logic [1:0]  issueGroup,
    input logic        overflow
);

    int         pend [NUM_GROUPS];  // Strobed minus issued, per group
    int         totalPend;
    int         runLen;             // Back-to-back issues of lastGroup
    int         curRun;             // Streak including this cycle's issue
    int         failCount;          // Summed into the testbench result
    logic [1:0] lastGroup;
    logic       lastValid;
    logic       otherPend;          // Some other group still waiting
    logic       cmdReal;

    assign cmdReal = cmdValid && (cmd[15:14] != NOP);  // NOPs never queue

    always_comb begin
        totalPend = 0;
        otherPend = 1'b0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            totalPend += pend[g];
            if (g != int'(issueGroup) && pend[g] > 0) begin
                otherPend = 1'b1;
            end
        end
        curRun = (lastValid && issueGroup == lastGroup) ? runLen + 1 : 1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                pend[g] <= 0;
            end
            runLen    <= 0;
            lastGroup <= '0;
            lastValid <= 1'b0;
        end else begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                pend[g] <= pend[g] + int'(cmdReal && cmd[13:12] == 2'(g))
                                   - int'(issueValid && issueGroup == 2'(g));
            end
            lastValid <= issueValid;  // Streak breaks on any gap
            if (issueValid) begin
                lastGroup <= issueGroup;
                runLen    <= curRun;
            end
        end
    end

    // Outputs quiet through reset and the first cycle after it
    resetQuiet: assert property (@(posedge clk) !rst_n |=> (!issueValid && !overflow))
        else begin
            $error("issueValid or overflow high during or right after reset");
            failCount++;
        end

    // Empty scheduler, idle arbiter: two cycles to the issue strobe
    minLatency: assert property (@(posedge clk) disable iff (!rst_n)
        (cmdReal && totalPend == 0 && !issueValid && !overflow)
            |-> ##2 (issueValid && issueGroup == $past(cmd[13:12], 2)))
        else begin
            $error("single command on an idle scheduler missed the two-cycle issue");
            failCount++;
        end

    burstLimit: assert property (@(posedge clk) disable iff (!rst_n)
        (issueValid && otherPend && !overflow) |-> (curRun <= BURST_LIMIT))
        else begin
            $error("group kept issuing past its burst limit with others waiting");
            failCount++;
        end

    // Sticky until reset
    overflowSticky: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> overflow)
        else begin
            $error("overflow dropped without a reset");
            failCount++;
        end

endmodule

//--- testbench/tbBankSched.sv
`timescale 1ns/1ps

module tbBankSched import schedPkg::*; ();

    localparam int QUEUE_DEPTH  = 4;
    localparam int BURST_LIMIT  = 3;
    localparam int RANDOM_CMDS  = 300;
    localparam int LAT_ROUNDS   = 8;
    localparam int BURST_ROUNDS = 6;
    localparam int FLOOD_CMDS   = 32;   // Well above what the drain rate absorbs
    localparam int HOLD_CYCLES  = 20;
    // Rough cycle budget of all tests
    localparam int TEST_CYCLES  = 8 + 2 * RANDOM_CMDS + LAT_ROUNDS * 12
                                + BURST_ROUNDS * NUM_GROUPS * 2 + FLOOD_CMDS + HOLD_CYCLES + 20;

    logic        clk;
    logic        rst_n;
    logic        cmdValid;
    logic [15:0] cmd;
    logic        issueValid;
    cmdOp_t      issueOp;
    logic [1:0]  issueGroup;
    logic [1:0]  issueBank;
    logic [9:0]  issueRow;
    logic [8:0]  issueCol;
    logic        issueChop;
    logic        overflow;

    logic [15:0] modelQ [NUM_GROUPS][$];  // Expected words in arrival order
    logic [31:0] lfsr = 32'h8a18_b664;
    string       testName = "reset";
    int          errCount;
    int          checkCount;
    int          testCount;
    int          errAtStart;
    int          checksAtStart;
    logic        rotationCheck = 1'b0;
    logic        sawOverflow = 1'b0;    // Model no longer exact once set
    logic        haveLast = 1'b0;
    logic [1:0]  lastGrp;

    bankSchedTop #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .BURST_LIMIT (BURST_LIMIT)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueGroup (issueGroup),
        .issueBank  (issueBank),
        .issueRow   (issueRow),
        .issueCol   (issueCol),
        .issueChop  (issueChop),
        .overflow   (overflow)
    );

    bind bankSchedTop bankSchedAsserts #(.BURST_LIMIT(BURST_LIMIT)) asserts_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .issueValid (issueValid),
        .issueGroup (issueGroup),
        .overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic nextBit();
        nextBit = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    // Random non-NOP word for one group
    function automatic logic [15:0] makeCmd(input logic [1:0] grp);
        logic [1:0] op;
        op = 2'(randBits(2));
        if (op == NOP) begin
            op = RD;
        end
        return {op, grp, 12'(randBits(12))};
    endfunction

    function automatic int modelTotal();
        int n;
        n = 0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            n += modelQ[g].size();
        end
        return n;
    endfunction

    function automatic logic overDepth();
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (modelQ[g].size() > QUEUE_DEPTH) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // First group after 'from' in A-B-C-D order with work left, -1 if none
    function automatic int nextPending(input logic [1:0] from);
        logic [1:0] idx;
        for (int k = 1; k < NUM_GROUPS; k++) begin
            idx = from + 2'(k);
            if (modelQ[idx].size() > 0) begin
                return int'(idx);
            end
        end
        return -1;
    endfunction

    // Rebuild the word through the view that the opcode selects
    function automatic logic [15:0] decodeIssue();
        if (issueOp == ACT) begin
            return {issueOp, issueGroup, issueBank, issueRow};
        end
        return {issueOp, issueGroup, issueBank, issueChop, issueCol};
    endfunction

    function automatic int totalErrors();
        return errCount + dut_i.asserts_i.failCount;
    endfunction

    task automatic sendCmd(input logic valid, input logic [15:0] word);
        @(posedge clk);
        #10;
        cmdValid = valid;
        cmd      = word;
        if (valid && word[15:14] != NOP) begin
            modelQ[word[13:12]].push_back(word);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) sendCmd(1'b0, 16'h0000);
    endtask

    task automatic waitDrain();
        while (modelTotal() != 0) begin
            idle(1);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #10;
        rst_n    = 1'b0;
        cmdValid = 1'b0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            modelQ[g].delete();
        end
        repeat (4) @(posedge clk);
        #10;
        rst_n       = 1'b1;
        sawOverflow = 1'b0;
        haveLast    = 1'b0;
    endtask

    task automatic beginTest(input string name);
        testName      = name;
        errAtStart    = totalErrors();
        checksAtStart = checkCount;
    endtask

    task automatic endTest();
        testCount++;
        $display("Test %-14s finished: %0d checks, %0d errors", testName,
                 checkCount - checksAtStart, totalErrors() - errAtStart);
    endtask

    // Sampled mid-cycle, away from the edge
    always @(negedge clk) begin : issueMonitor
        logic [1:0]  grpIdx;
        logic [15:0] expWord;
        logic [15:0] actWord;
        int          expGrp;
        if (rst_n && overflow && !sawOverflow) begin
            sawOverflow = 1'b1;
            checkCount++;
            assert (overDepth()) else begin
                $display("Overflow rose while no group held more than the queue depth");
                errCount++;
            end
        end
        if (rst_n && issueValid) begin
            grpIdx = issueGroup;
            if (modelQ[grpIdx].size() == 0) begin
                $display("Group %0d issued a command that was never sent", grpIdx);
                errCount++;
            end else begin
                expWord = modelQ[grpIdx][0];
                actWord = decodeIssue();
                if (rotationCheck && haveLast && grpIdx != lastGrp) begin
                    expGrp = nextPending(lastGrp);  // Hand-over target
                    if (expGrp >= 0) begin
                        checkCount++;
                        assert (expGrp == int'(grpIdx)) else begin
                            $display("ERR %s rotation expected group %0d actual %0d",
                                     testName, expGrp, grpIdx);
                            errCount++;
                        end
                    end
                end
                if (!sawOverflow) begin
                    checkCount++;
                    assert (actWord == expWord) else begin
                        $display("ERR %s group %0d expected %h actual %h",
                                 testName, grpIdx, expWord, actWord);
                        errCount++;
                    end
                end
                void'(modelQ[grpIdx].pop_front());
            end
            lastGrp  = grpIdx;
            haveLast = 1'b1;
        end
    end

    task automatic runRandom();
        logic [15:0] word;
        logic        valid;
        beginTest("randomOrder");
        for (int i = 0; i < RANDOM_CMDS; i++) begin
            valid = (randBits(2) != 0);  // About three in four cycles
            word  = 16'(randBits(16));   // NOPs included
            if (valid && word[15:14] != NOP && modelQ[word[13:12]].size() >= QUEUE_DEPTH) begin
                valid = 1'b0;            // Keep within depth
            end
            sendCmd(valid, word);
        end
        idle(1);
        waitDrain();
        endTest();
    endtask

    task automatic runLatency();
        beginTest("minLatency");
        for (int r = 0; r < LAT_ROUNDS; r++) begin
            waitDrain();
            idle(3);  // Arbiter back in IDLE
            sendCmd(1'b1, makeCmd(2'(randBits(2))));
            idle(1);
            waitDrain();
        end
        endTest();
    endtask

    task automatic runBurstRotation();
        beginTest("burstRotation");
        for (int r = 0; r < BURST_ROUNDS; r++) begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                if (modelQ[g].size() < QUEUE_DEPTH) begin
                    sendCmd(1'b1, makeCmd(2'(g)));
                end else begin
                    idle(1);
                end
            end
        end
        idle(3);
        rotationCheck = 1'b1;  // Hand-overs from here on see every load
        waitDrain();
        rotationCheck = 1'b0;
        endTest();
    endtask

    task automatic runFlood();
        beginTest("overflow");
        for (int g = 1; g < NUM_GROUPS; g++) begin
            sendCmd(1'b1, makeCmd(2'(g)));
            sendCmd(1'b1, makeCmd(2'(g)));
        end
        for (int i = 0; i < FLOOD_CMDS; i++) begin
            sendCmd(1'b1, makeCmd(2'd0));  // Group A only
        end
        idle(2);
        checkCount++;
        assert (overflow) else begin
            $display("Overflow never rose while group A was flooded");
            errCount++;
        end
        idle(HOLD_CYCLES);
        applyReset();
        idle(1);
        checkCount++;
        assert (!overflow) else begin
            $display("Overflow still set after reset");
            errCount++;
        end
        endTest();
    endtask

    initial begin : watchdog
        repeat (TEST_CYCLES * 4) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES * 4);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        cmdValid = 1'b0;
        cmd      = '0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        beginTest("reset");
        idle(2);
        checkCount++;
        assert (!issueValid && !overflow) else begin
            $display("issueValid or overflow set after reset");
            errCount++;
        end
        endTest();
        runRandom();
        runLatency();
        runBurstRotation();
        runFlood();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 testCount, checkCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
